//--- design/fb_consts.svh
`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

// ****************************************
// frame buffer geometry
// ****************************************

// one pixel on the user ports
`define FB_PIXEL_W        16

// pixels packed into one memory word
`define FB_PIX_PER_WORD   4

// interleaved ram banks, selected by the low word address bits
`define FB_NUM_BANKS      4

// words held in each bank
`define FB_BANK_DEPTH     64

`endif

//--- design/fb_pkg.sv
`default_nettype none
`include "fb_consts.svh"

package fb_pkg;

    // ****************************************
    // vector types
    // ****************************************
    typedef logic [`FB_PIXEL_W-1:0]                     pixel_t;
    typedef logic [`FB_PIX_PER_WORD*`FB_PIXEL_W-1:0]    word_t;      // lane 0 in low bits
    typedef logic [$clog2(`FB_PIX_PER_WORD)-1:0]        lane_t;
    typedef logic [$clog2(`FB_NUM_BANKS)-1:0]           bank_sel_t;  // low word addr bits
    typedef logic [$clog2(`FB_BANK_DEPTH)-1:0]          bank_row_t;  // upper word addr bits
    typedef logic [$bits(bank_row_t)+$bits(bank_sel_t)-1:0] word_addr_t;
    typedef logic [$bits(word_addr_t)+$bits(lane_t)-1:0]    pix_addr_t;

    // ****************************************
    // request structs
    // ****************************************
    typedef struct packed {
        logic       valid;
        word_addr_t addr;
        word_t      data;
    } mem_wr_t;

    typedef struct packed {
        logic       valid;
        word_addr_t addr;
        lane_t      lane;   // pixel wanted from the returned word
    } mem_rd_t;

    typedef struct packed {
        logic      en;
        bank_row_t row;
        word_t     data;
    } bank_wr_t;

    typedef struct packed {
        logic      en;
        bank_row_t row;
    } bank_rd_t;

endpackage

`default_nettype wire

//--- design/pixel_packer.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_consts.svh"

module pixel_packer (
    input  wire                    i_sys_clk,
    input  wire                    i_rst_n,
    input  wire                    i_wr_rst,    // reload pointer, drop partial word
    input  wire                    i_wr_req,
    input  wire fb_pkg::pixel_t    i_wr_data,
    input  wire fb_pkg::pix_addr_t i_wr_addr,
    output fb_pkg::mem_wr_t        o_mem_wr
);

    fb_pkg::pix_addr_t  wr_ptr;         // next pixel position
    fb_pkg::lane_t      wr_lane;
    fb_pkg::word_t      asm_word;       // lanes collected so far
    fb_pkg::word_t      asm_next;
    logic               word_done;
    logic               wr_vld_q;
    fb_pkg::word_addr_t wr_addr_q;
    fb_pkg::word_t      wr_data_q;

    assign wr_lane   = fb_pkg::lane_t'(wr_ptr);
    assign word_done = i_wr_req && !i_wr_rst &&
                       (wr_lane == fb_pkg::lane_t'(`FB_PIX_PER_WORD - 1));

    // drop the incoming pixel into its lane
    always_comb begin
        asm_next = asm_word;
        asm_next[wr_lane*`FB_PIXEL_W +: `FB_PIXEL_W] = i_wr_data;
    end

    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            wr_vld_q <= 1'b0;
        end else begin
            wr_vld_q <= word_done;                  // one pulse per full word
            if (i_wr_rst) begin
                wr_ptr <= i_wr_addr & ~fb_pkg::pix_addr_t'(`FB_PIX_PER_WORD - 1);
            end else if (i_wr_req) begin
                wr_ptr <= wr_ptr + 1'b1;            // wraps at the top
            end
        end
    end

    // lanes left over from an abandoned word get overwritten from lane 0
    always_ff @(posedge i_sys_clk) begin
        if (i_wr_req) begin
            asm_word <= asm_next;
        end
        if (word_done) begin
            wr_addr_q <= fb_pkg::word_addr_t'(wr_ptr >> $bits(fb_pkg::lane_t));
            wr_data_q <= asm_next;
        end
    end

    assign o_mem_wr = '{valid: wr_vld_q, addr: wr_addr_q, data: wr_data_q};

endmodule

`default_nettype wire

//--- design/bank_router.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_consts.svh"

module bank_router (
    input  wire                                  i_sys_clk,
    input  wire                                  i_rst_n,
    input  wire fb_pkg::mem_wr_t                 i_mem_wr,
    input  wire fb_pkg::mem_rd_t                 i_mem_rd,
    output fb_pkg::bank_wr_t [`FB_NUM_BANKS-1:0] o_bank_wr,
    output fb_pkg::bank_rd_t [`FB_NUM_BANKS-1:0] o_bank_rd
);

    fb_pkg::bank_sel_t        wr_sel;
    fb_pkg::bank_sel_t        rd_sel;
    fb_pkg::bank_row_t        wr_row;
    fb_pkg::bank_row_t        rd_row;
    logic [`FB_NUM_BANKS-1:0] wr_en_q;       // one hot or zero
    logic [`FB_NUM_BANKS-1:0] rd_en_q;
    fb_pkg::bank_row_t        wr_row_q;
    fb_pkg::bank_row_t        rd_row_q;
    fb_pkg::word_t            wr_data_q;

    // ****************************************
    // address split, bank in the low bits
    // ****************************************
    assign wr_sel = fb_pkg::bank_sel_t'(i_mem_wr.addr);
    assign rd_sel = fb_pkg::bank_sel_t'(i_mem_rd.addr);
    assign wr_row = fb_pkg::bank_row_t'(i_mem_wr.addr >> $bits(fb_pkg::bank_sel_t));
    assign rd_row = fb_pkg::bank_row_t'(i_mem_rd.addr >> $bits(fb_pkg::bank_sel_t));

    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            wr_en_q <= '0;
            rd_en_q <= '0;
        end else begin
            for (int b = 0; b < `FB_NUM_BANKS; b++) begin
                wr_en_q[b] <= i_mem_wr.valid && (wr_sel == fb_pkg::bank_sel_t'(b));
                rd_en_q[b] <= i_mem_rd.valid && (rd_sel == fb_pkg::bank_sel_t'(b));
            end
        end
    end

    // row and word are shared by all banks, the enable picks one
    always_ff @(posedge i_sys_clk) begin
        if (i_mem_wr.valid) begin
            wr_row_q  <= wr_row;
            wr_data_q <= i_mem_wr.data;
        end
        if (i_mem_rd.valid) begin
            rd_row_q <= rd_row;
        end
    end

    always_comb begin
        for (int b = 0; b < `FB_NUM_BANKS; b++) begin
            o_bank_wr[b] = '{en: wr_en_q[b], row: wr_row_q, data: wr_data_q};
            o_bank_rd[b] = '{en: rd_en_q[b], row: rd_row_q};
        end
    end

endmodule

`default_nettype wire

//--- design/ram_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_consts.svh"

module ram_bank (
    input  wire                   i_sys_clk,
    input  wire fb_pkg::bank_wr_t i_bank_wr,
    input  wire fb_pkg::bank_rd_t i_bank_rd,
    output fb_pkg::word_t         o_rd_word     // holds between reads
);

    // ****************************************
    // word storage, maps to block ram
    // ****************************************
    fb_pkg::word_t mem [0:`FB_BANK_DEPTH-1];

    always_ff @(posedge i_sys_clk) begin
        if (i_bank_wr.en) begin
            mem[i_bank_wr.row] <= i_bank_wr.data;
        end
    end

    // same row written and read in one cycle returns the old word
    always_ff @(posedge i_sys_clk) begin
        if (i_bank_rd.en) begin
            o_rd_word <= mem[i_bank_rd.row];
        end
    end

endmodule

`default_nettype wire

//--- design/pixel_unpacker.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_consts.svh"

module pixel_unpacker (
    input  wire                                 i_sys_clk,
    input  wire                                 i_rst_n,
    input  wire                                 i_rd_rst,     // reload read pointer
    input  wire                                 i_rd_req,
    input  wire fb_pkg::pix_addr_t              i_rd_addr,
    output fb_pkg::mem_rd_t                     o_mem_rd,
    input  wire fb_pkg::word_t [`FB_NUM_BANKS-1:0] i_bank_words,
    output logic                                o_rd_valid,
    output fb_pkg::pixel_t                      o_rd_data
);

    fb_pkg::pix_addr_t  rd_ptr;
    logic               req_vld_q;
    fb_pkg::word_addr_t req_addr_q;
    fb_pkg::lane_t      req_lane_q;
    logic [1:0]         tag_vld;        // [0] router stage, [1] bank stage
    fb_pkg::bank_sel_t  tag_sel [2];
    fb_pkg::lane_t      tag_lane [2];
    fb_pkg::word_t      sel_word;
    fb_pkg::pixel_t     sel_pixel;

    // ****************************************
    // pointer and request register
    // ****************************************
    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            rd_ptr    <= '0;
            req_vld_q <= 1'b0;
        end else begin
            req_vld_q <= i_rd_req;
            if (i_rd_rst) begin
                rd_ptr <= i_rd_addr;            // any pixel, no alignment
            end else if (i_rd_req) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (i_rd_req) begin
            req_addr_q <= fb_pkg::word_addr_t'(rd_ptr >> $bits(fb_pkg::lane_t));
            req_lane_q <= fb_pkg::lane_t'(rd_ptr);
        end
    end

    assign o_mem_rd = '{valid: req_vld_q, addr: req_addr_q, lane: req_lane_q};

    // ****************************************
    // tags follow the router and bank stages
    // ****************************************
    always_ff @(posedge i_sys_clk) begin
        if (!i_rst_n) begin
            tag_vld    <= '0;
            o_rd_valid <= 1'b0;
        end else begin
            tag_vld    <= {tag_vld[0], o_mem_rd.valid};
            o_rd_valid <= tag_vld[1];
        end
    end

    always_ff @(posedge i_sys_clk) begin
        tag_sel[0]  <= fb_pkg::bank_sel_t'(o_mem_rd.addr);
        tag_lane[0] <= o_mem_rd.lane;
        tag_sel[1]  <= tag_sel[0];
        tag_lane[1] <= tag_lane[0];
        if (tag_vld[1]) begin
            o_rd_data <= sel_pixel;
        end
    end

    assign sel_word  = i_bank_words[tag_sel[1]];    // bank that answered
    assign sel_pixel = sel_word[tag_lane[1]*`FB_PIXEL_W +: `FB_PIXEL_W];

endmodule

`default_nettype wire

//--- design/frame_buf_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_consts.svh"

module frame_buf_top (
    input  wire                    i_sys_clk,
    input  wire                    i_rst_n,
    // write port
    input  wire                    i_user_wr_rst,
    input  wire                    i_user_wr_req,
    input  wire fb_pkg::pixel_t    i_user_wr_data,
    input  wire fb_pkg::pix_addr_t i_user_wr_addr,
    // read port
    input  wire                    i_user_rd_rst,
    input  wire                    i_user_rd_req,
    input  wire fb_pkg::pix_addr_t i_user_rd_addr,
    output wire                    o_user_rd_valid,   // four cycles after the strobe
    output wire fb_pkg::pixel_t    o_user_rd_data
);

    wire fb_pkg::mem_wr_t                    mem_wr;
    wire fb_pkg::mem_rd_t                    mem_rd;
    wire fb_pkg::bank_wr_t [`FB_NUM_BANKS-1:0] bank_wr;
    wire fb_pkg::bank_rd_t [`FB_NUM_BANKS-1:0] bank_rd;
    wire fb_pkg::word_t    [`FB_NUM_BANKS-1:0] bank_words;

    // ****************************************
    // write side
    // ****************************************
    pixel_packer u_pixel_packer (
        .i_sys_clk (i_sys_clk),
        .i_rst_n   (i_rst_n),
        .i_wr_rst  (i_user_wr_rst),
        .i_wr_req  (i_user_wr_req),
        .i_wr_data (i_user_wr_data),
        .i_wr_addr (i_user_wr_addr),
        .o_mem_wr  (mem_wr)
    );

    bank_router u_bank_router (
        .i_sys_clk (i_sys_clk),
        .i_rst_n   (i_rst_n),
        .i_mem_wr  (mem_wr),
        .i_mem_rd  (mem_rd),
        .o_bank_wr (bank_wr),
        .o_bank_rd (bank_rd)
    );

    // ****************************************
    // interleaved banks
    // ****************************************
    for (genvar g = 0; g < `FB_NUM_BANKS; g++) begin : g_bank
        ram_bank u_ram_bank (
            .i_sys_clk (i_sys_clk),
            .i_bank_wr (bank_wr[g]),
            .i_bank_rd (bank_rd[g]),
            .o_rd_word (bank_words[g])
        );
    end

    // ****************************************
    // read side
    // ****************************************
    pixel_unpacker u_pixel_unpacker (
        .i_sys_clk    (i_sys_clk),
        .i_rst_n      (i_rst_n),
        .i_rd_rst     (i_user_rd_rst),
        .i_rd_req     (i_user_rd_req),
        .i_rd_addr    (i_user_rd_addr),
        .o_mem_rd     (mem_rd),
        .i_bank_words (bank_words),
        .o_rd_valid   (o_user_rd_valid),
        .o_rd_data    (o_user_rd_data)
    );

endmodule

`default_nettype wire

//--- testbench/fb_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_consts.svh"

module fb_checker (
    input  wire                    i_sys_clk,
    input  wire                    i_rst_n,
    input  wire                    i_wr_rst,
    input  wire                    i_wr_req,
    input  wire fb_pkg::pixel_t    i_wr_data,
    input  wire fb_pkg::pix_addr_t i_wr_addr,
    input  wire                    i_rd_rst,
    input  wire                    i_rd_req,
    input  wire fb_pkg::pix_addr_t i_rd_addr,
    input  wire                    i_rd_valid,
    input  wire fb_pkg::pixel_t    i_rd_data,
    output int                     o_pending,      // reads still owed by the DUT
    output int                     o_mismatch_cnt,
    output int                     o_protocol_cnt
);

    localparam int NUM_PIX = `FB_NUM_BANKS * `FB_BANK_DEPTH * `FB_PIX_PER_WORD;

    fb_pkg::pixel_t    model [NUM_PIX];               // full words only
    fb_pkg::pixel_t    lane_buf [`FB_PIX_PER_WORD];
    fb_pkg::pix_addr_t wr_ptr = '0;
    fb_pkg::pix_addr_t rd_ptr = '0;
    fb_pkg::pixel_t    exp_q [$];
    int                due_q [$];                     // cycle each pixel is due
    int                cyc = 0;
    int                pending_cnt = 0;
    int                mismatch_cnt = 0;
    int                protocol_cnt = 0;

    assign o_pending      = pending_cnt;
    assign o_mismatch_cnt = mismatch_cnt;
    assign o_protocol_cnt = protocol_cnt;

    always @(posedge i_sys_clk) begin
        fb_pkg::pix_addr_t base;
        fb_pkg::pixel_t    exp_pix;
        int                due;
        if (!i_rst_n) begin
            if (i_rd_valid === 1'b1) begin
                $display("ERROR: o_user_rd_valid high during reset at cycle %0d", cyc);
                protocol_cnt++;
            end
            wr_ptr = '0;
            rd_ptr = '0;
        end else begin
            // ****************************************
            // dut outputs as held before this edge
            // ****************************************
            if (i_rd_valid === 1'b1 && exp_q.size() == 0) begin
                $display("ERROR: o_user_rd_valid high with no read pending, cycle %0d", cyc);
                protocol_cnt++;
            end else if (i_rd_valid === 1'b1) begin
                exp_pix = exp_q.pop_front();
                due     = due_q.pop_front();
                if (due != cyc) begin
                    $display("ERROR: read valid came at cycle %0d, expected at %0d", cyc, due);
                    protocol_cnt++;
                end
                if (i_rd_data !== exp_pix) begin
                    $display("MISMATCH o_user_rd_data got %h expected %h", i_rd_data, exp_pix);
                    mismatch_cnt++;
                end
            end else if (i_rd_valid !== 1'b0) begin
                $display("ERROR: o_user_rd_valid is unknown at cycle %0d", cyc);
                protocol_cnt++;
            end
            while (due_q.size() > 0 && due_q[0] <= cyc) begin
                exp_pix = exp_q.pop_front();
                due     = due_q.pop_front();
                $display("ERROR: no o_user_rd_valid for the read due at cycle %0d", due);
                protocol_cnt++;
            end
            // lane bits of the write base are dropped
            if (i_wr_rst) begin
                wr_ptr = i_wr_addr - (i_wr_addr % `FB_PIX_PER_WORD);
            end else if (i_wr_req) begin
                lane_buf[wr_ptr % `FB_PIX_PER_WORD] = i_wr_data;
                if (wr_ptr % `FB_PIX_PER_WORD == `FB_PIX_PER_WORD - 1) begin
                    base = wr_ptr - (wr_ptr % `FB_PIX_PER_WORD);
                    for (int l = 0; l < `FB_PIX_PER_WORD; l++) begin
                        model[base + l] = lane_buf[l];
                    end
                end
                wr_ptr = wr_ptr + 1'b1;                   // wraps at the top
            end
            if (i_rd_rst) begin
                rd_ptr = i_rd_addr;
            end else if (i_rd_req) begin
                exp_q.push_back(model[rd_ptr]);
                due_q.push_back(cyc + 4);                 // four register stages
                rd_ptr = rd_ptr + 1'b1;
            end
        end
        pending_cnt = exp_q.size();
        cyc++;
    end

endmodule

`default_nettype wire

//--- testbench/tb_frame_buf.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_consts.svh"

module tb_frame_buf;

    localparam int TIMEOUT_CYC = 100;
    localparam int NUM_ENTRIES = 10;

    typedef struct packed {
        logic              is_read;
        fb_pkg::pix_addr_t base;
        logic [10:0]       count;
        logic              rand_data;     // else address pattern
    } stim_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              wr_rst;
    logic              wr_req;
    fb_pkg::pixel_t    wr_data;
    fb_pkg::pix_addr_t wr_addr;
    logic              rd_rst;
    logic              rd_req;
    fb_pkg::pix_addr_t rd_addr;
    wire               rd_valid;
    wire fb_pkg::pixel_t rd_data;
    int                chk_pending;
    int                chk_mismatch;
    int                chk_protocol;
    stim_t             stim_table [NUM_ENTRIES];
    integer            seed;
    int                timeout_cnt;
    logic              timed_out;

    always #10 clk = ~clk;

    frame_buf_top i_dut (
        .i_sys_clk       (clk),
        .i_rst_n         (rst_n),
        .i_user_wr_rst   (wr_rst),
        .i_user_wr_req   (wr_req),
        .i_user_wr_data  (wr_data),
        .i_user_wr_addr  (wr_addr),
        .i_user_rd_rst   (rd_rst),
        .i_user_rd_req   (rd_req),
        .i_user_rd_addr  (rd_addr),
        .o_user_rd_valid (rd_valid),
        .o_user_rd_data  (rd_data)
    );

    fb_checker u_checker (
        .i_sys_clk      (clk),
        .i_rst_n        (rst_n),
        .i_wr_rst       (wr_rst),
        .i_wr_req       (wr_req),
        .i_wr_data      (wr_data),
        .i_wr_addr      (wr_addr),
        .i_rd_rst       (rd_rst),
        .i_rd_req       (rd_req),
        .i_rd_addr      (rd_addr),
        .i_rd_valid     (rd_valid),
        .i_rd_data      (rd_data),
        .o_pending      (chk_pending),
        .o_mismatch_cnt (chk_mismatch),
        .o_protocol_cnt (chk_protocol)
    );

    function automatic fb_pkg::pixel_t addr_pattern(input fb_pkg::pix_addr_t a);
        return fb_pkg::pixel_t'({~a[5:0], a});   // whole address in the pixel
    endfunction

    task automatic write_burst(input stim_t e);
        fb_pkg::pix_addr_t a;
        a = e.base & ~fb_pkg::pix_addr_t'(`FB_PIX_PER_WORD - 1);
        @(posedge clk);
        #2 wr_rst = 1'b1;
        wr_addr = e.base;
        for (int i = 0; i < e.count; i++) begin
            @(posedge clk);
            #2 wr_rst = 1'b0;
            wr_req  = 1'b1;
            wr_data = e.rand_data ? fb_pkg::pixel_t'($random(seed)) : addr_pattern(a);
            a       = a + 1'b1;
        end
        @(posedge clk);
        #2 wr_rst = 1'b0;
        wr_req = 1'b0;
    endtask

    task automatic read_burst(input stim_t e);
        @(posedge clk);
        #2 rd_rst = 1'b1;
        rd_addr = e.base;
        for (int i = 0; i < e.count; i++) begin
            @(posedge clk);
            #2 rd_rst = 1'b0;
            rd_req = 1'b1;                      // back to back strobes
        end
        @(posedge clk);
        #2 rd_rst = 1'b0;
        rd_req = 1'b0;
    endtask

    task automatic wait_idle();
        int i;
        i = 0;
        while (chk_pending != 0 && i < TIMEOUT_CYC) begin
            @(posedge clk);
            #2;
            i++;
        end
        if (chk_pending != 0) begin
            $display("ERROR: reads still outstanding after %0d cycles", TIMEOUT_CYC);
            timeout_cnt++;
            timed_out = 1'b1;
        end
        repeat (3) @(posedge clk);              // last word lands in its bank
        #2;
    endtask

    // ****************************************
    // stimulus table
    // ****************************************
    initial begin
        stim_table[0] = '{1'b0, 10'd0,    11'd1024, 1'b1};  // fill all memory
        stim_table[1] = '{1'b0, 10'd0,    11'd256,  1'b0};
        stim_table[2] = '{1'b1, 10'd0,    11'd256,  1'b0};
        stim_table[3] = '{1'b1, 10'd1002, 11'd40,   1'b0};  // unaligned, wraps
        stim_table[4] = '{1'b0, 10'd512,  11'd10,   1'b0};  // partial last word
        stim_table[5] = '{1'b0, 10'd701,  11'd6,    1'b0};  // restart mid word
        stim_table[6] = '{1'b1, 10'd508,  11'd20,   1'b0};
        stim_table[7] = '{1'b1, 10'd696,  11'd16,   1'b0};
        stim_table[8] = '{1'b0, 10'd1020, 11'd8,    1'b1};  // write wraps
        stim_table[9] = '{1'b1, 10'd1018, 11'd12,   1'b0};
        seed        = 32'h2073603e;
        timeout_cnt = 0;
        timed_out   = 1'b0;
        rst_n   = 1'b0;
        wr_rst  = 1'b0;
        wr_req  = 1'b0;
        wr_data = '0;
        wr_addr = '0;
        rd_rst  = 1'b0;
        rd_req  = 1'b0;
        rd_addr = '0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (5) @(posedge clk);              // valid must stay low here
        for (int n = 0; n < NUM_ENTRIES && !timed_out; n++) begin
            if (stim_table[n].is_read) begin
                read_burst(stim_table[n]);
            end else begin
                write_burst(stim_table[n]);
            end
            wait_idle();
        end
        $display("error counts: %0d mismatch, %0d protocol, %0d timeout",
                 chk_mismatch, chk_protocol, timeout_cnt);
        if (chk_mismatch + chk_protocol + timeout_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- frame_buf.f
+incdir+design
design/fb_pkg.sv
design/pixel_packer.sv
design/bank_router.sv
design/ram_bank.sv
design/pixel_unpacker.sv
design/frame_buf_top.sv
testbench/fb_checker.sv
testbench/tb_frame_buf.sv

//--- Bender.yml
package:
  name: frame_buf

sources:
  - include_dirs:
      - design
    files:
      - design/fb_pkg.sv
      - design/pixel_packer.sv
      - design/bank_router.sv
      - design/ram_bank.sv
      - design/pixel_unpacker.sv
      - design/frame_buf_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/fb_checker.sv
      - testbench/tb_frame_buf.sv
